// File: design/sd_xfer_pkg.sv
`default_nettype none

package sd_xfer_pkg;

  // sector counts and sector numbers
  typedef logic [31:0] sector_t;
  // card block address, block addressing mode
  typedef logic [31:0] blk_addr_t;
  typedef logic [15:0] rca_t;
  typedef logic [5:0]  cmd_index_t;
  typedef logic [31:0] cmd_arg_t;

  // response outcome, valid with the done strobe
  typedef logic [1:0]  cmd_status_t;

  localparam cmd_status_t CMD_ST_OK      = 2'd0;
  localparam cmd_status_t CMD_ST_NO_CARD = 2'd1;
  localparam cmd_status_t CMD_ST_ERROR   = 2'd2;

  // command indices used by the transfer
  localparam cmd_index_t CMD_SET_BLOCKLEN      = 6'd16;
  localparam cmd_index_t CMD_APP               = 6'd55;
  localparam cmd_index_t ACMD_SET_WR_BLK_ERASE = 6'd23;
  localparam cmd_index_t CMD_READ_MULTI        = 6'd18;
  localparam cmd_index_t CMD_WRITE_MULTI       = 6'd25;
  localparam cmd_index_t CMD_STOP              = 6'd12;

  // all four DAT lines released by the card
  localparam logic [3:0] DAT_IDLE = 4'hF;

  typedef enum logic [3:0] {
    ST_IDLE,
    ST_BLOCKLEN,
    ST_APP,
    ST_SET_COUNT,
    ST_OPEN,
    ST_DATA,
    ST_STOP,
    ST_STOP_BUSY,
    ST_INACTIVE,
    ST_DONE
  } xfer_state_e;

endpackage

`default_nettype wire

// File: design/sd_track_if.sv
`timescale 1ns/10ps
`default_nettype none

interface sd_track_if;

  // pulses from the sequencer
  logic                   clear;
  logic                   block_done;

  // tracker results
  sd_xfer_pkg::sector_t   count;
  sd_xfer_pkg::sector_t   remaining;
  sd_xfer_pkg::blk_addr_t block_addr;
  logic                   all_done;

  modport tracker (
    input  clear, block_done,
    output count, remaining, block_addr, all_done
  );

  // remaining count is latched for the data engine at open
  modport seq (
    output clear, block_done,
    input  all_done, remaining
  );

  modport issuer (
    input  remaining, block_addr
  );

endinterface

`default_nettype wire

// File: design/sd_sector_tracker.sv
`timescale 1ns/10ps
`default_nettype none

module sd_sector_tracker (
  input  logic                   i_clk,
  input  logic                   i_rst_n,
  input  sd_xfer_pkg::sector_t   i_trans_sectors,
  input  sd_xfer_pkg::blk_addr_t i_trans_addr,
  sd_track_if.tracker            trk
);

  sd_xfer_pkg::sector_t count_q;

  // completed sectors of the current transfer
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      count_q <= '0;
    end else if (trk.clear) begin
      count_q <= '0;
    end else if (trk.block_done) begin
      count_q <= count_q + sd_xfer_pkg::sector_t'(1);
    end
  end

  assign trk.count = count_q;

  // what is left for the next ACMD23
  assign trk.remaining = i_trans_sectors - count_q;

  // resume point, first sector not yet moved
  assign trk.block_addr = i_trans_addr + sd_xfer_pkg::blk_addr_t'(count_q);

  assign trk.all_done = (count_q == i_trans_sectors);

endmodule

`default_nettype wire

// File: design/sd_cmd_issuer.sv
`timescale 1ns/10ps
`default_nettype none

module sd_cmd_issuer #(
  parameter int BLOCK_LEN = 512
) (
  input  logic                     i_clk,
  input  logic                     i_rst_n,
  input  sd_xfer_pkg::xfer_state_e i_state,
  input  logic                     i_write,
  input  sd_xfer_pkg::rca_t        i_rca,
  input  logic                     i_cmd_done,
  sd_track_if.issuer               trk,
  output logic                     o_cmd_valid,
  output sd_xfer_pkg::cmd_index_t  o_cmd_index,
  output sd_xfer_pkg::cmd_arg_t    o_cmd_arg
);

  logic                    is_cmd;
  sd_xfer_pkg::cmd_index_t next_index;
  sd_xfer_pkg::cmd_arg_t   next_arg;

  // command for the requested state, zero elsewhere
  always_comb begin
    is_cmd     = 1'b1;
    next_index = '0;
    next_arg   = '0;
    case (i_state)
      sd_xfer_pkg::ST_BLOCKLEN: begin
        next_index = sd_xfer_pkg::CMD_SET_BLOCKLEN;
        next_arg   = sd_xfer_pkg::cmd_arg_t'(BLOCK_LEN);
      end
      sd_xfer_pkg::ST_APP: begin
        // rca in the upper half, stuff bits below
        next_index = sd_xfer_pkg::CMD_APP;
        next_arg   = {i_rca, 16'h0000};
      end
      sd_xfer_pkg::ST_SET_COUNT: begin
        next_index = sd_xfer_pkg::ACMD_SET_WR_BLK_ERASE;
        next_arg   = sd_xfer_pkg::cmd_arg_t'(trk.remaining);
      end
      sd_xfer_pkg::ST_OPEN: begin
        next_index = i_write ? sd_xfer_pkg::CMD_WRITE_MULTI : sd_xfer_pkg::CMD_READ_MULTI;
        next_arg   = sd_xfer_pkg::cmd_arg_t'(trk.block_addr);
      end
      sd_xfer_pkg::ST_STOP: begin
        next_index = sd_xfer_pkg::CMD_STOP;
      end
      default: begin
        is_cmd = 1'b0;
      end
    endcase
  end

  // valid drops with the done strobe, the state moves on in the same cycle
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_cmd_valid <= 1'b0;
      o_cmd_index <= '0;
      o_cmd_arg   <= '0;
    end else begin
      o_cmd_valid <= is_cmd && !i_cmd_done;
      o_cmd_index <= next_index;
      o_cmd_arg   <= next_arg;
    end
  end

endmodule

`default_nettype wire

// File: design/sd_xfer_seq.sv
`timescale 1ns/10ps
`default_nettype none

module sd_xfer_seq (
  input  logic                     i_clk,
  input  logic                     i_rst_n,
  input  logic                     i_card_ready,
  input  logic                     i_trans_start,
  input  logic                     i_trans_write,
  input  sd_xfer_pkg::sector_t     i_trans_sectors,
  input  logic                     i_cmd_done,
  input  sd_xfer_pkg::cmd_status_t i_cmd_status,
  input  logic                     i_block_done,
  input  logic                     i_data_end,
  input  logic [3:0]               i_sd_dat,
  output sd_xfer_pkg::xfer_state_e o_state,
  output logic                     o_data_run,
  output logic                     o_data_write,
  output sd_xfer_pkg::sector_t     o_data_sectors,
  output logic                     o_data_abort,
  output logic                     o_read_done,
  output logic                     o_write_done,
  output logic [1:0]               o_busy,
  sd_track_if.seq                  trk
);

  sd_xfer_pkg::xfer_state_e state;
  sd_xfer_pkg::xfer_state_e state_nxt;
  sd_xfer_pkg::xfer_state_e cmd_follow;
  logic [1:0]               start_sync;
  logic [3:0]               dat_q;
  logic                     start_ok;
  logic                     no_card;

  // start edge, only taken from idle with the card ready
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      start_sync <= 2'b00;
    end else begin
      start_sync <= {start_sync[0], i_trans_start};
    end
  end

  assign start_ok = (state == sd_xfer_pkg::ST_IDLE) && (start_sync == 2'b01) && i_card_ready;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      dat_q <= sd_xfer_pkg::DAT_IDLE;
    end else begin
      dat_q <= i_sd_dat;
    end
  end

  // where each command state goes after a good response
  always_comb begin
    case (state)
      sd_xfer_pkg::ST_BLOCKLEN:  cmd_follow = sd_xfer_pkg::ST_APP;
      sd_xfer_pkg::ST_APP:       cmd_follow = sd_xfer_pkg::ST_SET_COUNT;
      sd_xfer_pkg::ST_SET_COUNT: cmd_follow = sd_xfer_pkg::ST_OPEN;
      sd_xfer_pkg::ST_OPEN:      cmd_follow = sd_xfer_pkg::ST_DATA;
      default:                   cmd_follow = sd_xfer_pkg::ST_STOP_BUSY;
    endcase
  end

  always_comb begin
    state_nxt = state;
    case (state)
      sd_xfer_pkg::ST_IDLE: begin
        if (start_ok) begin
          state_nxt = sd_xfer_pkg::ST_BLOCKLEN;
        end
      end
      sd_xfer_pkg::ST_BLOCKLEN, sd_xfer_pkg::ST_APP, sd_xfer_pkg::ST_SET_COUNT,
      sd_xfer_pkg::ST_OPEN, sd_xfer_pkg::ST_STOP: begin
        // status arrives together with the done strobe
        if (i_cmd_done) begin
          if (i_cmd_status == sd_xfer_pkg::CMD_ST_ERROR) begin
            state_nxt = sd_xfer_pkg::ST_IDLE;
          end else if (i_cmd_status == sd_xfer_pkg::CMD_ST_NO_CARD) begin
            state_nxt = sd_xfer_pkg::ST_INACTIVE;
          end else begin
            state_nxt = cmd_follow;
          end
        end
      end
      sd_xfer_pkg::ST_DATA: begin
        if (i_data_end) begin
          state_nxt = (i_trans_sectors != '0) ? sd_xfer_pkg::ST_STOP : sd_xfer_pkg::ST_DONE;
        end
      end
      sd_xfer_pkg::ST_STOP_BUSY: begin
        // card holds DAT0 low while programming
        if (dat_q == sd_xfer_pkg::DAT_IDLE) begin
          state_nxt = trk.all_done ? sd_xfer_pkg::ST_DONE : sd_xfer_pkg::ST_APP;
        end
      end
      default: begin
        state_nxt = sd_xfer_pkg::ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state <= sd_xfer_pkg::ST_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  assign o_state = state;

  // tracker pulses
  assign trk.clear      = start_ok;
  assign trk.block_done = (state == sd_xfer_pkg::ST_DATA) && i_block_done;

  // data engine control
  assign o_data_run   = (state == sd_xfer_pkg::ST_DATA);
  assign o_data_abort = ((state == sd_xfer_pkg::ST_STOP) ||
                         (state == sd_xfer_pkg::ST_STOP_BUSY)) && !trk.all_done;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_data_write <= 1'b0;
      o_read_done  <= 1'b0;
      o_write_done <= 1'b0;
      no_card      <= 1'b0;
    end else begin
      if (start_ok) begin
        o_data_write <= i_trans_write;
      end
      o_read_done  <= trk.block_done && !o_data_write;
      o_write_done <= trk.block_done && o_data_write;
      // sticky until the transfer completes or restarts
      if (state == sd_xfer_pkg::ST_INACTIVE) begin
        no_card <= 1'b1;
      end else if ((state == sd_xfer_pkg::ST_DONE) || start_ok) begin
        no_card <= 1'b0;
      end
    end
  end

  // run length handed to the engine
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_data_sectors <= '0;
    end else if (state == sd_xfer_pkg::ST_OPEN) begin
      o_data_sectors <= trk.remaining;
    end
  end

  assign o_busy[1] = (state != sd_xfer_pkg::ST_IDLE) && (state != sd_xfer_pkg::ST_DONE);
  assign o_busy[0] = no_card;

endmodule

`default_nettype wire

// File: design/sd_xfer_top.sv
`timescale 1ns/10ps
`default_nettype none

module sd_xfer_top #(
  parameter int BLOCK_LEN = 512
) (
  input  logic                     i_clk,
  input  logic                     i_rst_n,
  input  logic                     i_card_ready,
  input  sd_xfer_pkg::rca_t        i_rca,
  input  logic                     i_trans_start,
  input  logic                     i_trans_write,
  input  sd_xfer_pkg::sector_t     i_trans_sectors,
  input  sd_xfer_pkg::blk_addr_t   i_trans_addr,
  input  logic                     i_cmd_done,
  input  sd_xfer_pkg::cmd_status_t i_cmd_status,
  input  logic                     i_block_done,
  input  logic                     i_data_end,
  input  logic [3:0]               i_sd_dat,
  output logic                     o_cmd_valid,
  output sd_xfer_pkg::cmd_index_t  o_cmd_index,
  output sd_xfer_pkg::cmd_arg_t    o_cmd_arg,
  output logic                     o_data_run,
  output logic                     o_data_write,
  output sd_xfer_pkg::sector_t     o_data_sectors,
  output logic                     o_data_abort,
  output logic                     o_read_done,
  output logic                     o_write_done,
  output sd_xfer_pkg::sector_t     o_sector_count,
  output logic [1:0]               o_busy
);

  sd_xfer_pkg::xfer_state_e state;

  sd_track_if trk ();

  sd_xfer_seq u_seq (
    .i_clk           (i_clk),
    .i_rst_n         (i_rst_n),
    .i_card_ready    (i_card_ready),
    .i_trans_start   (i_trans_start),
    .i_trans_write   (i_trans_write),
    .i_trans_sectors (i_trans_sectors),
    .i_cmd_done      (i_cmd_done),
    .i_cmd_status    (i_cmd_status),
    .i_block_done    (i_block_done),
    .i_data_end      (i_data_end),
    .i_sd_dat        (i_sd_dat),
    .o_state         (state),
    .o_data_run      (o_data_run),
    .o_data_write    (o_data_write),
    .o_data_sectors  (o_data_sectors),
    .o_data_abort    (o_data_abort),
    .o_read_done     (o_read_done),
    .o_write_done    (o_write_done),
    .o_busy          (o_busy),
    .trk             (trk.seq)
  );

  sd_sector_tracker u_tracker (
    .i_clk           (i_clk),
    .i_rst_n         (i_rst_n),
    .i_trans_sectors (i_trans_sectors),
    .i_trans_addr    (i_trans_addr),
    .trk             (trk.tracker)
  );

  // direction for CMD18/25 follows the latched write level
  sd_cmd_issuer #(
    .BLOCK_LEN (BLOCK_LEN)
  ) u_issuer (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_state     (state),
    .i_write     (o_data_write),
    .i_rca       (i_rca),
    .i_cmd_done  (i_cmd_done),
    .trk         (trk.issuer),
    .o_cmd_valid (o_cmd_valid),
    .o_cmd_index (o_cmd_index),
    .o_cmd_arg   (o_cmd_arg)
  );

  assign o_sector_count = trk.count;

endmodule

`default_nettype wire

// File: sim/sd_xfer_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module sd_xfer_asserts (
  input logic                    i_clk,
  input logic                    i_rst_n,
  input logic                    i_cmd_valid,
  input sd_xfer_pkg::cmd_index_t i_cmd_index,
  input logic                    i_data_run,
  input logic                    i_block_done,
  input logic                    i_read_done,
  input logic                    i_write_done
);

  int fail_count = 0;

  // command line stays quiet while sectors move
  a_no_cmd_in_data : assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_data_run |-> !i_cmd_valid)
    else begin
      $error("o_cmd_valid high while o_data_run is high");
      fail_count++;
    end

  // each done pulse answers one engine sector and names one direction
  a_one_done_kind : assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_read_done || i_write_done) |-> ($past(i_block_done) && !(i_read_done && i_write_done)))
    else begin
      $error("done pulse without a sector before it, or read and write done together");
      fail_count++;
    end

  // index may only change when valid drops
  a_index_stable : assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_cmd_valid |=> (!i_cmd_valid || $stable(i_cmd_index)))
    else begin
      $error("o_cmd_index changed while o_cmd_valid was high");
      fail_count++;
    end

endmodule

bind sd_xfer_top sd_xfer_asserts u_asserts (
  .i_clk        (i_clk),
  .i_rst_n      (i_rst_n),
  .i_cmd_valid  (o_cmd_valid),
  .i_cmd_index  (o_cmd_index),
  .i_data_run   (o_data_run),
  .i_block_done (i_block_done),
  .i_read_done  (o_read_done),
  .i_write_done (o_write_done)
);

`default_nettype wire

// File: sim/sd_xfer_tb.sv
`timescale 1ns/10ps
`default_nettype none

module sd_xfer_tb;

  localparam int          BLOCK_LEN     = 512;
  localparam logic [15:0] RCA           = 16'hB37A;
  // 7 transfers, worst case per command is response delay plus DAT hold
  localparam int          TOTAL_CMDS    = 42;
  localparam int          TOTAL_SECTORS = 20;
  // start level kept high well past the end of one transfer
  localparam int          LONG_HOLD     = 200;
  localparam int          CYCLE_LIMIT   = TOTAL_CMDS * 16 + TOTAL_SECTORS * 2 + 8 * 80 +
                                          LONG_HOLD;

  // abort level, command index, argument
  typedef logic [38:0] cmd_rec_t;

  logic        i_clk, i_rst_n, i_card_ready, i_trans_start, i_trans_write;
  logic [15:0] i_rca;
  logic [31:0] i_trans_sectors, i_trans_addr;
  logic        i_cmd_done, i_block_done, i_data_end;
  logic [1:0]  i_cmd_status;
  logic [3:0]  i_sd_dat;
  logic        o_cmd_valid, o_data_run, o_data_write, o_data_abort, o_read_done, o_write_done;
  logic [5:0]  o_cmd_index;
  logic [31:0] o_cmd_arg, o_data_sectors, o_sector_count;
  logic [1:0]  o_busy;

  cmd_rec_t    exp_q[$];
  cmd_rec_t    exp_rec;
  int          runs[$];
  int          run_i, cmd_seen, fail_at, n_cap, n_rd, n_wr;
  int          sectors_left;
  logic        exp_wr;
  int          errors = 0;
  int          n_checks = 0;
  int          n_tests = 0;
  logic [1:0]  fail_status;
  logic [31:0] rng = 32'd60359;
  logic        valid_d = 1'b0;

  sd_xfer_top #(.BLOCK_LEN(BLOCK_LEN)) dut (.*);

  initial begin
    i_clk = 1'b0;
    forever #2 i_clk = ~i_clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // expected commands: blocklen once, then per run 55/23/18or25/12
  function automatic void build_expected(input logic wr, input int n, input logic [31:0] addr,
                                         input logic [15:0] rca, input int plan[$],
                                         input int limit);
    int done;
    done = 0;
    exp_q.delete();
    exp_q.push_back({1'b0, 6'd16, 32'(BLOCK_LEN)});
    foreach (plan[r]) begin
      exp_q.push_back({1'b0, 6'd55, rca, 16'h0000});
      exp_q.push_back({1'b0, 6'd23, 32'(n - done)});
      exp_q.push_back({1'b0, (wr ? 6'd25 : 6'd18), addr + 32'(done)});
      done += plan[r];
      exp_q.push_back({(done != n), 6'd12, 32'h0});
    end
    while (exp_q.size() > limit) exp_q.pop_back();
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    assert (got == exp)
      else begin
        $display("CHECK FAILED %s exp 0x%0h got 0x%0h", name, exp, got);
        errors++;
      end
  endtask

  task automatic report_test(input string name, input int err0);
    n_tests++;
    if (errors == err0) $display("%-28s ok", name);
    else $display("%-28s fail", name);
  endtask

  task automatic wait_transfer_end();
    @(negedge i_clk);
    while (!o_busy[1]) @(negedge i_clk);
    while (o_busy[1]) @(negedge i_clk);
  endtask

  task automatic run_transfer(input string name, input logic wr, input int n,
                              input logic [31:0] addr, input int fail_cmd,
                              input logic [1:0] fail_st, input int n_cmds,
                              input logic [1:0] exp_busy, input int exp_blocks, input int hold);
    int err0;
    err0 = errors;
    build_expected(wr, n, addr, RCA, runs, n_cmds);
    fail_at      = fail_cmd;
    fail_status  = fail_st;
    cmd_seen     = 0;
    run_i        = 0;
    n_cap        = 0;
    n_rd         = 0;
    n_wr         = 0;
    sectors_left = n;
    exp_wr       = wr;
    @(posedge i_clk);
    i_trans_write   <= wr;
    i_trans_sectors <= n;
    i_trans_addr    <= addr;
    i_trans_start   <= 1'b1;
    fork
      begin
        repeat (hold) @(posedge i_clk);
        i_trans_start <= 1'b0;
      end
      wait_transfer_end();
    join
    repeat (4) @(negedge i_clk);
    check_value("commands issued", n_cap, n_cmds);
    check_value(wr ? "o_write_done pulses" : "o_read_done pulses", wr ? n_wr : n_rd, exp_blocks);
    check_value(wr ? "o_read_done pulses" : "o_write_done pulses", wr ? n_rd : n_wr, 0);
    check_value("o_sector_count", o_sector_count, exp_blocks);
    check_value("o_busy", o_busy, exp_busy);
    report_test(name, err0);
  endtask

  // card side: answers commands, holds DAT low after CMD12
  initial begin : responder
    logic [5:0] idx;
    forever begin
      @(negedge i_clk);
      if (o_cmd_valid) begin
        idx = o_cmd_index;
        cmd_seen++;
        rng = xorshift(rng);
        repeat (rng % 4) @(negedge i_clk);
        @(posedge i_clk);
        i_cmd_done   <= 1'b1;
        i_cmd_status <= (cmd_seen == fail_at) ? fail_status : sd_xfer_pkg::CMD_ST_OK;
        if (idx == 6'd12) i_sd_dat <= 4'h0;
        @(posedge i_clk);
        i_cmd_done   <= 1'b0;
        i_cmd_status <= sd_xfer_pkg::CMD_ST_OK;
        if (idx == 6'd12) begin
          rng = xorshift(rng);
          repeat (rng % 8) @(posedge i_clk);
          i_sd_dat <= 4'hF;
        end
      end
    end
  end

  // line engine, planned sector count per run then end
  initial begin : engine
    forever begin
      @(negedge i_clk);
      if (o_data_run) begin
        // run length is what the request still lacks at open
        check_value("o_data_sectors", o_data_sectors, sectors_left);
        check_value("o_data_write", o_data_write, exp_wr);
        sectors_left -= runs[run_i];
        repeat (runs[run_i]) begin
          @(posedge i_clk);
          i_block_done <= 1'b1;
          @(posedge i_clk);
          i_block_done <= 1'b0;
        end
        @(posedge i_clk);
        i_data_end <= 1'b1;
        @(posedge i_clk);
        i_data_end <= 1'b0;
        run_i++;
      end
    end
  end

  always @(negedge i_clk) begin : compare
    if (o_cmd_valid && !valid_d) begin
      n_cap++;
      n_checks++;
      assert (i_sd_dat == 4'hF)
        else begin
          $display("command %0d issued while the DAT lines were held busy", o_cmd_index);
          errors++;
        end
      assert (exp_q.size() > 0)
        else begin
          $display("command %0d issued when no command was expected", o_cmd_index);
          errors++;
        end
      if (exp_q.size() > 0) begin
        exp_rec = exp_q.pop_front();
        check_value("o_cmd_index", o_cmd_index, exp_rec[37:32]);
        check_value("o_cmd_arg", o_cmd_arg, exp_rec[31:0]);
        check_value("o_data_abort", o_data_abort, exp_rec[38]);
      end
    end
    if (o_read_done) n_rd++;
    if (o_write_done) n_wr++;
    valid_d = o_cmd_valid;
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles <= CYCLE_LIMIT) begin
      @(posedge i_clk);
      cycles++;
    end
    $display("timeout after %0d cycles, a transfer never finished", cycles);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin : main
    int err0;
    i_rst_n = 1'b0;
    i_card_ready = 1'b1;
    i_rca = RCA;
    i_trans_start = 1'b0;
    i_trans_write = 1'b0;
    i_trans_sectors = '0;
    i_trans_addr = '0;
    i_cmd_done = 1'b0;
    i_cmd_status = sd_xfer_pkg::CMD_ST_OK;
    i_block_done = 1'b0;
    i_data_end = 1'b0;
    i_sd_dat = 4'hF;
    repeat (3) @(posedge i_clk);
    i_rst_n <= 1'b1;
    @(negedge i_clk);
    check_value("outputs after reset", {o_cmd_valid, o_data_run, o_data_abort, o_read_done,
                                        o_write_done, o_busy}, '0);
    runs = {5};
    run_transfer("read 5 sectors", 1'b0, 5, 32'h0000_1000, 0, 2'd0, 5, 2'b00, 5, 2);
    runs = {4};
    run_transfer("write 4 sectors", 1'b1, 4, 32'h0002_0000, 0, 2'd0, 5, 2'b00, 4, 2);
    runs = {2, 4};
    run_transfer("read resumed after 2 of 6", 1'b0, 6, 32'h0000_0300, 0, 2'd0, 9, 2'b00, 6, 2);
    runs = {1, 1, 1};
    run_transfer("write in three runs", 1'b1, 3, 32'h00AB_C000, 0, 2'd0, 13, 2'b00, 3, 2);
    runs = {3};
    run_transfer("error on ACMD23", 1'b1, 3, 32'h0000_0040, 3, sd_xfer_pkg::CMD_ST_ERROR,
                 3, 2'b00, 0, 2);
    // start while the card is not ready
    err0 = errors;
    exp_q.delete();
    n_cap = 0;
    @(posedge i_clk);
    i_card_ready  <= 1'b0;
    i_trans_start <= 1'b1;
    repeat (3) @(posedge i_clk);
    i_trans_start <= 1'b0;
    repeat (20) @(negedge i_clk);
    check_value("commands issued", n_cap, 0);
    check_value("o_busy", o_busy, 2'b00);
    report_test("start with card not ready", err0);
    @(posedge i_clk);
    i_card_ready <= 1'b1;
    runs = {2};
    run_transfer("no card on CMD55", 1'b0, 2, 32'h0000_0800, 2, sd_xfer_pkg::CMD_ST_NO_CARD,
                 2, 2'b01, 0, 2);
    run_transfer("start held high", 1'b0, 2, 32'h0000_0900, 0, 2'd0, 5, 2'b00, 2, LONG_HOLD);
    errors = errors + dut.u_asserts.fail_count;
    $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
design/sd_xfer_pkg.sv
design/sd_track_if.sv
design/sd_sector_tracker.sv
design/sd_cmd_issuer.sv
design/sd_xfer_seq.sv
design/sd_xfer_top.sv
sim/sd_xfer_asserts.sv
sim/sd_xfer_tb.sv

// File: Bender.yml
package:
  name: sd_xfer

sources:
  - files:
      - design/sd_xfer_pkg.sv
      - design/sd_track_if.sv
      - design/sd_sector_tracker.sv
      - design/sd_cmd_issuer.sv
      - design/sd_xfer_seq.sv
      - design/sd_xfer_top.sv
  - target: test
    files:
      - sim/sd_xfer_asserts.sv
      - sim/sd_xfer_tb.sv
